// ==== rtl/cnt_cmd_ctrl.sv ====
// Command front end of the event counter
// Accepts commands over valid/ready, decodes them into counter actions and
// returns one registered response per accepted command
// Commits are refused while the fault latch holds the lockout

`timescale 1ns/10ps

module cnt_cmd_ctrl
  import cnt_pkg::*;
#(
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Command channel from the client
  input  logic             cmd_valid_i,
  input  cnt_cmd_t         cmd_i,
  output logic             cmd_ready_o,
  // Response channel to the client
  output logic             rsp_valid_o,
  output cnt_rsp_t         rsp_o,
  input  logic             rsp_ready_i,
  // Counter interface
  input  logic [Width-1:0] cnt_after_commit_i,
  input  logic             lock_i,
  output logic             clr_o,
  output logic             set_o,
  output logic [Width-1:0] set_cnt_o,
  output logic             incr_en_o,
  output logic             decr_en_o,
  output logic [Width-1:0] step_o,
  output logic             commit_o
);

  logic     accept;
  logic     rsp_valid_q;
  cnt_rsp_t rsp_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // A new command fits when the response slot is empty or drains this cycle
  assign cmd_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  // At most one action is raised, and only for a valid command at the head
  always_comb begin
    clr_o     = 1'b0;
    set_o     = 1'b0;
    incr_en_o = 1'b0;
    decr_en_o = 1'b0;
    if (cmd_valid_i) begin
      case (cmd_i.op)
        OpClr:   clr_o     = 1'b1;
        OpSet:   set_o     = 1'b1;
        OpIncr:  incr_en_o = 1'b1;
        OpDecr:  decr_en_o = 1'b1;
        default: ;
      endcase
    end
  end

  // The value field serves both as set value and as step
  assign set_cnt_o = cmd_i.value;
  assign step_o    = cmd_i.value;

  // A change is stored only for an accepted, committing command while unlocked
  assign commit_o = accept && cmd_i.commit && !lock_i;

  ////////////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // The payload is captured on acceptance and held until the next one
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.count     <= cnt_after_commit_i;
      rsp_q.committed <= commit_o;
      rsp_q.alert     <= lock_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== rtl/cnt_fault_latch.sv ====
// Sticky fault record of the event counter
// Sets on the first counter error and only a reset clears it
// Its output locks out commits and drives the external fatal alert

`timescale 1ns/10ps

module cnt_fault_latch (
  input  logic clk_i,
  input  logic rst_ni,
  // Registered sum-check error from the counter
  input  logic err_i,
  // Commit lockout towards the command controller
  output logic lock_o,
  // External fatal alert
  output logic fatal_alert_o
);

  logic fault_q;

  ////////////////////////////////////////////////////////////////////////////
  // Fault record
  ////////////////////////////////////////////////////////////////////////////

  // Once set the record stays set, whatever the counter does afterwards
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
    end else if (err_i) begin
      fault_q <= 1'b1;
    end
  end

  // Lockout and alert come from the same flop
  assign lock_o        = fault_q;
  assign fatal_alert_o = fault_q;

endmodule

// ==== rtl/cnt_pkg.sv ====
// Unit-level types of the event counter
// Holds the counter width, the command opcodes and the command and response
// records that cross the client channels of the unit

package cnt_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Type for counter widths
  typedef int unsigned cnt_width_t;

  // Default width of the counter, passed down by the top level
  localparam cnt_width_t CntWidth = 8;

  // A count, a set value or a step
  typedef logic [CntWidth-1:0] cnt_val_t;

  ////////////////////////////////////////////////////////////////////////////
  // Command channel
  ////////////////////////////////////////////////////////////////////////////

  // Opcodes understood by the command controller
  typedef enum logic [2:0] {
    OpHold = 3'd0,
    OpClr  = 3'd1,
    OpSet  = 3'd2,
    OpIncr = 3'd3,
    OpDecr = 3'd4
  } cnt_op_e;

  // One command from the client
  // The value field is the set value for OpSet and the step for OpIncr and OpDecr
  // Without the commit bit the command is only a preview
  typedef struct packed {
    cnt_op_e  op;
    cnt_val_t value;
    logic     commit;
  } cnt_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////////////

  // One response per accepted command
  // The count is the value the counter takes if the command is committed
  typedef struct packed {
    cnt_val_t count;
    logic     committed;
    logic     alert;
  } cnt_rsp_t;

endpackage

// ==== rtl/cnt_unit_top.sv ====
// Top level of the hardened event counter unit
// Connects the command controller, the cross counter and the fault latch,
// and sets the counter width and reset value for all of them

`timescale 1ns/10ps

module cnt_unit_top
  import cnt_pkg::*;
  import prim_count_pkg::*;
#(
  parameter int       CntWidth   = cnt_pkg::CntWidth,
  parameter cnt_val_t ResetValue = '0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     cmd_valid_i,
  input  cnt_cmd_t cmd_i,
  output logic     cmd_ready_o,
  output logic     rsp_valid_o,
  output cnt_rsp_t rsp_o,
  input  logic     rsp_ready_i,
  output cnt_val_t count_o,
  output logic     fatal_alert_o
);

  // Decoded counter actions from the controller
  logic                clr;
  logic                set;
  logic [CntWidth-1:0] set_cnt;
  logic                incr_en;
  logic                decr_en;
  logic [CntWidth-1:0] step;
  logic                commit;
  // Feedback from the counter and the fault latch
  logic [CntWidth-1:0] cnt_after_commit;
  logic                err;
  logic                lock;

  cnt_cmd_ctrl #(
    .Width (CntWidth)
  ) u_cmd_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cmd_valid_i        (cmd_valid_i),
    .cmd_i              (cmd_i),
    .cmd_ready_o        (cmd_ready_o),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_o              (rsp_o),
    .rsp_ready_i        (rsp_ready_i),
    .cnt_after_commit_i (cnt_after_commit),
    .lock_i             (lock),
    .clr_o              (clr),
    .set_o              (set),
    .set_cnt_o          (set_cnt),
    .incr_en_o          (incr_en),
    .decr_en_o          (decr_en),
    .step_o             (step),
    .commit_o           (commit)
  );

  // Every action is in use at this level
  prim_count #(
    .Width           (CntWidth),
    .ResetValue      (ResetValue),
    .PossibleActions ({$bits(action_mask_t){1'b1}})
  ) u_prim_count (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .clr_i              (clr),
    .set_i              (set),
    .set_cnt_i          (set_cnt),
    .incr_en_i          (incr_en),
    .decr_en_i          (decr_en),
    .step_i             (step),
    .commit_i           (commit),
    .cnt_o              (count_o),
    .cnt_after_commit_o (cnt_after_commit),
    .err_o              (err)
  );

  cnt_fault_latch u_fault_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .err_i         (err),
    .lock_o        (lock),
    .fatal_alert_o (fatal_alert_o)
  );

endmodule

// ==== rtl/prim_count.sv ====
// Hardened cross counter with clear, set, step increment and step decrement
// A primary counter counts up and a secondary counter mirrors it downwards,
// so the two always sum to all-ones; a broken sum raises a registered error
// Changes are stored only on commit, while the next value is always visible

`timescale 1ns/10ps

module prim_count
  import prim_count_pkg::*;
#(
  parameter int               Width           = 8,
  // Count held by the primary counter after reset or clear
  parameter logic [Width-1:0] ResetValue      = '0,
  // Actions this instance may use, the others are tied off
  parameter action_mask_t     PossibleActions = {$bits(action_mask_t){1'b1}}
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             set_i,
  input  logic [Width-1:0] set_cnt_i,
  input  logic             incr_en_i,
  input  logic             decr_en_i,
  input  logic [Width-1:0] step_i,
  input  logic             commit_i,
  output logic [Width-1:0] cnt_o,
  output logic [Width-1:0] cnt_after_commit_o,
  output logic             err_o
);

  // One counter word
  typedef logic [Width-1:0] word_t;

  // Index 0 is the primary counter and index 1 the secondary
  localparam int NumCnt = 2;
  typedef logic [NumCnt-1:0][Width-1:0] cnt_pair_t;

  localparam word_t     MaxValue    = {Width{1'b1}};
  // The secondary counter starts at the complement of the primary one
  localparam cnt_pair_t ResetValues = {MaxValue - ResetValue, ResetValue};

  logic      clr_act;
  logic      set_act;
  logic      incr_act;
  logic      decr_act;
  cnt_pair_t cnt_d;
  cnt_pair_t cnt_q;
  logic [Width:0] sum;
  logic      err_d;
  logic      err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Action masking
  ////////////////////////////////////////////////////////////////////////////

  // Actions missing from the mask can never reach the counters
  assign clr_act  = clr_i     && ((PossibleActions & Clr)  != '0);
  assign set_act  = set_i     && ((PossibleActions & Set)  != '0);
  assign incr_act = incr_en_i && ((PossibleActions & Incr) != '0);
  assign decr_act = decr_en_i && ((PossibleActions & Decr) != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Next-state logic for both counters
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NumCnt; k++) begin : gen_cnt
    logic           up_en;
    logic           dn_en;
    word_t          set_val;
    logic [Width:0] ext_cnt;
    logic           oflow;
    logic           uflow;
    word_t          cnt_sat;

    if (k == 0) begin : gen_primary
      assign up_en   = incr_act;
      assign dn_en   = decr_act;
      assign set_val = set_cnt_i;
    end else begin : gen_secondary
      // The secondary counter moves against the primary one
      assign up_en   = decr_act;
      assign dn_en   = incr_act;
      assign set_val = MaxValue - set_cnt_i;
    end

    // One extra bit catches the carry or the borrow of the step
    assign ext_cnt = dn_en ? ({1'b0, cnt_q[k]} - {1'b0, step_i}) :
                             ({1'b0, cnt_q[k]} + {1'b0, step_i});

    // A carry on the way up or a borrow on the way down means the limit was crossed
    assign oflow = up_en && ext_cnt[Width];
    assign uflow = dn_en && ext_cnt[Width];

    // Stop at the limits instead of wrapping around
    assign cnt_sat = oflow ? MaxValue :
                     uflow ? '0       : ext_cnt[Width-1:0];

    // Clear beats set, set beats counting
    // Both count enables together leave the counter where it is
    assign cnt_d[k] = clr_act          ? ResetValues[k] :
                      set_act          ? set_val        :
                      (up_en ^ dn_en)  ? cnt_sat        : cnt_q[k];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Counter storage
  ////////////////////////////////////////////////////////////////////////////

  // Only committed changes are stored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= ResetValues;
    end else if (commit_i) begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sum check
  ////////////////////////////////////////////////////////////////////////////

  // Primary plus secondary must equal all-ones with no carry out
  assign sum   = {1'b0, cnt_q[0]} + {1'b0, cnt_q[1]};
  assign err_d = (sum != {1'b0, MaxValue});

  // The error is registered so the fault latch sees a clean flop output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_d;
    end
  end

  assign err_o              = err_q;
  assign cnt_o              = cnt_q[0];
  // The would-be primary count, whether or not the change is committed
  assign cnt_after_commit_o = cnt_d[0];

endmodule

// ==== rtl/prim_count_pkg.sv ====
// Action mask definitions for the hardened cross counter primitive
// An instance names the actions it may see with a mask built from these bits
// Actions left out of the mask are tied off inside the counter

package prim_count_pkg;

  // One bit per counter action, set when the instance may use that action
  typedef logic [3:0] action_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Named action bits
  ////////////////////////////////////////////////////////////////////////////

  // Clear back to the reset value
  localparam action_mask_t Clr  = 4'b0001;
  // Load an explicit count
  localparam action_mask_t Set  = 4'b0010;
  // Count up by the step
  localparam action_mask_t Incr = 4'b0100;
  // Count down by the step
  localparam action_mask_t Decr = 4'b1000;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the event counter testbench with Verilator.
# The run fails when the log holds the fail message.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sources.f --top-module cnt_unit_tb \
  -o cnt_unit_sim > build.log 2>&1 \
  && ./obj_dir/cnt_unit_sim > sim.log 2>&1 \
  || echo "*** TEST FAILED ***" >> sim.log

cat build.log sim.log

grep -qF "*** TEST FAILED ***" sim.log \
  && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// ==== sources.f ====
rtl/prim_count_pkg.sv
rtl/cnt_pkg.sv
rtl/prim_count.sv
rtl/cnt_cmd_ctrl.sv
rtl/cnt_fault_latch.sv
rtl/cnt_unit_top.sv
testbench/cnt_unit_sva.sv
testbench/cnt_unit_checker.sv
testbench/cnt_unit_tb.sv

// ==== testbench/cnt_unit_checker.sv ====
// Reference model and scoreboard for the event counter unit
// Watches the DUT ports, predicts every response and the committed count,
// and counts mismatches for the closing summary of the testbench

`timescale 1ns/10ps

module cnt_unit_checker
  import cnt_pkg::*;
#(
  parameter cnt_val_t ResetValue = '0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     cmd_valid_i,
  input  cnt_cmd_t cmd_i,
  input  logic     cmd_ready_i,
  input  logic     rsp_valid_i,
  input  cnt_rsp_t rsp_i,
  input  logic     rsp_ready_i,
  input  cnt_val_t count_i,
  input  logic     fatal_alert_i,
  // Expected count from the stimulus table, when the command has one
  input  logic     exp_known_i,
  input  cnt_val_t exp_count_i,
  output int       err_count_o,
  output int       rsp_count_o
);

  localparam int MaxCount = (1 << CntWidth) - 1;

  // Responses owed to the client, oldest first
  cnt_rsp_t            model_q[$];
  // Table expectation per owed response whose top bit is set when one exists
  logic [CntWidth:0]   table_q[$];
  cnt_val_t            model_cnt = ResetValue;
  logic                accepted_q = 1'b0;
  logic                in_reset_q = 1'b1;
  int                  errors = 0;
  int                  responses = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Counter rules
  ////////////////////////////////////////////////////////////////////////////

  // Saturating count after one command, worked out in plain integers
  function automatic cnt_val_t next_count(cnt_val_t cur, cnt_cmd_t cmd);
    int s;
    s = int'(cur);
    case (cmd.op)
      OpClr:   s = int'(ResetValue);
      OpSet:   s = int'(cmd.value);
      OpIncr:  s = int'(cur) + int'(cmd.value);
      OpDecr:  s = int'(cur) - int'(cmd.value);
      default: ;
    endcase
    if (s > MaxCount) s = MaxCount;
    if (s < 0) s = 0;
    return cnt_val_t'(s);
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("ERROR t=%0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port watcher
  ////////////////////////////////////////////////////////////////////////////

  // Everything is sampled at the rising edge, before the DUT flops update
  always @(posedge clk_i) begin : watch
    cnt_rsp_t          exp_rsp;
    logic [CntWidth:0] tbl;
    if (!rst_ni) begin
      model_cnt  = ResetValue;
      model_q.delete();
      table_q.delete();
      accepted_q = 1'b0;
      in_reset_q = 1'b1;
    end else begin
      if (in_reset_q) begin
        check_value("count_o after reset", 32'(count_i), 32'(ResetValue));
        check_value("rsp_valid_o after reset", 32'(rsp_valid_i), 32'd0);
        check_value("cmd_ready_o after reset", 32'(cmd_ready_i), 32'd1);
        in_reset_q = 1'b0;
      end
      check_value("count_o", 32'(count_i), 32'(model_cnt));
      check_value("fatal_alert_o", 32'(fatal_alert_i), 32'd0);
      // Ready follows the free or draining response slot
      check_value("cmd_ready_o", 32'(cmd_ready_i),
                  32'(model_q.size() == 0 || rsp_ready_i));
      if (accepted_q && !rsp_valid_i) begin
        report_problem("no response one cycle after a command was accepted");
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (model_q.size() == 0) begin
          report_problem("response delivered with no accepted command pending");
        end else begin
          exp_rsp = model_q.pop_front();
          tbl     = table_q.pop_front();
          check_value("rsp_o.count", 32'(rsp_i.count), 32'(exp_rsp.count));
          check_value("rsp_o.committed", 32'(rsp_i.committed), 32'(exp_rsp.committed));
          check_value("rsp_o.alert", 32'(rsp_i.alert), 32'(exp_rsp.alert));
          if (tbl[CntWidth]) begin
            check_value("rsp_o.count (table)", 32'(rsp_i.count), 32'(tbl[CntWidth-1:0]));
          end
          responses++;
        end
      end
      // The model moves on the same edge that accepts the command
      accepted_q = cmd_valid_i && cmd_ready_i;
      if (accepted_q) begin
        exp_rsp.count     = next_count(model_cnt, cmd_i);
        exp_rsp.committed = cmd_i.commit;
        exp_rsp.alert     = 1'b0;
        model_q.push_back(exp_rsp);
        table_q.push_back({exp_known_i, exp_count_i});
        if (cmd_i.commit) model_cnt = exp_rsp.count;
      end
    end
  end

  assign err_count_o = errors;
  assign rsp_count_o = responses;

endmodule

// ==== testbench/cnt_unit_sva.sv ====
// Concurrent assertions for the event counter unit
// Bound into the top level so they see the secondary counter and the response channel

`timescale 1ns/10ps

module cnt_unit_sva
  import cnt_pkg::*;
#(
  parameter int Width = 8
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic [Width-1:0] cnt_pri_i,
  input logic [Width-1:0] cnt_sec_i,
  input logic             rsp_valid_i,
  input logic             rsp_ready_i,
  input cnt_rsp_t         rsp_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Counter invariant
  ////////////////////////////////////////////////////////////////////////////

  // Primary and secondary counts mirror each other around all-ones
  sum_all_ones: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ({1'b0, cnt_pri_i} + {1'b0, cnt_sec_i}) == {1'b0, {Width{1'b1}}})
    else $error("Primary and secondary counts no longer sum to all-ones");

  ////////////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////////////

  // A response that is not taken stays valid and unchanged
  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("Response changed or vanished while the consumer stalled");

endmodule

// The secondary count lives inside the counter primitive
bind cnt_unit_top cnt_unit_sva #(
  .Width (CntWidth)
) u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .cnt_pri_i     (count_o),
  .cnt_sec_i     (u_prim_count.cnt_q[1]),
  .rsp_valid_i   (rsp_valid_o),
  .rsp_ready_i   (rsp_ready_i),
  .rsp_i         (rsp_o)
);

// ==== testbench/cnt_unit_tb.sv ====
// Testbench top for the event counter unit
// Applies a table of commands with response stalls, then a seeded random
// section, and leaves all comparing to the checker instance

`timescale 1ns/10ps

module cnt_unit_tb
  import cnt_pkg::*;
();

  localparam cnt_val_t    ResetVal      = 8'h10;
  localparam int          NumEntries    = 22;
  localparam int          NumRandom     = 40;
  localparam int          TimeoutCycles = (NumEntries + NumRandom) * 4 + 20;
  localparam logic [31:0] RandSeed      = 32'he3b3b012;

  // One table row, stall is how long rsp_ready_i stays low from its drive edge
  typedef struct packed {
    cnt_op_e  op;
    cnt_val_t value;
    logic     commit;
    int       stall;
    cnt_val_t exp_count;
  } entry_t;

  logic     clk_i;
  logic     rst_ni;
  logic     cmd_valid_i;
  cnt_cmd_t cmd_i;
  logic     cmd_ready_o;
  logic     rsp_valid_o;
  cnt_rsp_t rsp_o;
  logic     rsp_ready_i;
  cnt_val_t count_o;
  logic     fatal_alert_o;
  logic     exp_known;
  cnt_val_t exp_count;
  int       err_count;
  int       rsp_count;
  int       stall_left;
  int       cycles;
  entry_t   stim_table[$];

  cnt_unit_top #(
    .ResetValue (ResetVal)
  ) dut (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i, .cmd_ready_o,
    .rsp_valid_o, .rsp_o, .rsp_ready_i, .count_o, .fatal_alert_o
  );

  cnt_unit_checker #(
    .ResetValue (ResetVal)
  ) u_checker (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i,
    .cmd_ready_i   (cmd_ready_o),
    .rsp_valid_i   (rsp_valid_o),
    .rsp_i         (rsp_o),
    .rsp_ready_i,
    .count_i       (count_o),
    .fatal_alert_i (fatal_alert_o),
    .exp_known_i   (exp_known),
    .exp_count_i   (exp_count),
    .err_count_o   (err_count),
    .rsp_count_o   (rsp_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Watchdog sized from the number of commands
  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic void add_entry(cnt_op_e op, cnt_val_t value, logic commit,
                                    int stall, cnt_val_t exp_cnt);
    entry_t e;
    e.op        = op;
    e.value     = value;
    e.commit    = commit;
    e.stall     = stall;
    e.exp_count = exp_cnt;
    stim_table.push_back(e);
  endfunction

  // Called on every falling edge the stimulus owns
  task automatic update_ready();
    if (stall_left > 0) begin
      rsp_ready_i = 1'b0;
      stall_left--;
    end else begin
      rsp_ready_i = 1'b1;
    end
  endtask

  // Drive one command and hold it until the rising edge that accepts it
  task automatic send_cmd(cnt_cmd_t cmd, int stall, logic known, cnt_val_t exp_cnt);
    @(negedge clk_i);
    stall_left  = stall;
    update_ready();
    cmd_valid_i = 1'b1;
    cmd_i       = cmd;
    exp_known   = known;
    exp_count   = exp_cnt;
    @(posedge clk_i);
    while (!cmd_ready_o) begin
      @(negedge clk_i);
      update_ready();
      @(posedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cnt_cmd_t cmd;
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    rsp_ready_i = 1'b1;
    exp_known   = 1'b0;
    exp_count   = '0;
    stall_left  = 0;
    void'($urandom(RandSeed));

    // Counts start at ResetVal, saturation rows hit both limits
    add_entry(OpIncr, 8'h05, 1'b1, 0, 8'h15);
    add_entry(OpDecr, 8'h03, 1'b1, 0, 8'h12);
    add_entry(OpSet,  8'h80, 1'b1, 0, 8'h80);
    add_entry(OpClr,  8'h00, 1'b1, 0, 8'h10);
    add_entry(OpIncr, 8'h20, 1'b0, 0, 8'h30);
    add_entry(OpSet,  8'hf0, 1'b1, 0, 8'hf0);
    add_entry(OpIncr, 8'h20, 1'b1, 0, 8'hff);
    add_entry(OpIncr, 8'h01, 1'b1, 0, 8'hff);
    add_entry(OpDecr, 8'h0f, 1'b1, 2, 8'hf0);
    add_entry(OpSet,  8'h04, 1'b1, 1, 8'h04);
    add_entry(OpDecr, 8'h10, 1'b1, 0, 8'h00);
    add_entry(OpDecr, 8'h01, 1'b1, 0, 8'h00);
    add_entry(OpHold, 8'haa, 1'b1, 0, 8'h00);
    add_entry(OpIncr, 8'h7f, 1'b1, 2, 8'h7f);
    add_entry(OpDecr, 8'h7f, 1'b0, 0, 8'h00);
    add_entry(OpHold, 8'h00, 1'b0, 0, 8'h7f);
    add_entry(OpIncr, 8'h80, 1'b1, 0, 8'hff);
    add_entry(OpDecr, 8'hff, 1'b1, 0, 8'h00);
    add_entry(OpSet,  8'h33, 1'b1, 1, 8'h33);
    add_entry(OpClr,  8'h55, 1'b0, 0, 8'h10);
    add_entry(OpDecr, 8'h34, 1'b1, 0, 8'h00);
    add_entry(OpIncr, 8'h10, 1'b1, 0, 8'h10);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (stim_table[i]) begin
      cmd.op     = stim_table[i].op;
      cmd.value  = stim_table[i].value;
      cmd.commit = stim_table[i].commit;
      send_cmd(cmd, stim_table[i].stall, 1'b1, stim_table[i].exp_count);
    end

    // Random commands have no table value, the checker model covers them
    for (int i = 0; i < NumRandom; i++) begin
      cmd.op     = cnt_op_e'(3'($urandom_range(0, 4)));
      cmd.value  = cnt_val_t'($urandom);
      cmd.commit = 1'($urandom);
      send_cmd(cmd, $urandom_range(0, 2), 1'b0, '0);
    end

    // Drain the last response
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    exp_known   = 1'b0;
    stall_left  = 0;
    update_ready();
    @(posedge clk_i);
    while (rsp_valid_o) @(posedge clk_i);
    repeat (2) @(posedge clk_i);

    if (rsp_count != NumEntries + NumRandom) begin
      $display("Number of responses does not match the number of commands sent");
    end
    $display("Summary: %0d errors, %0d of %0d responses checked",
             err_count, rsp_count, NumEntries + NumRandom);
    if (err_count == 0 && rsp_count == NumEntries + NumRandom) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
